// File: logic/fp_alu_pkg.sv
// ================================================
// FP ALU package
// Default number format and the types shared by the ALU blocks
// ================================================
package fp_alu_pkg;

    // ================================================
    // Default format
    // ================================================

    // IEEE-754 binary32 layout
    localparam int default_exp_bits = 8;
    localparam int default_man_bits = 23;

    // Half precision would be 5 and 10; the top passes the pair down

    // ================================================
    // Operation codes
    // ================================================

    // Code 2'd3 is unused and falls through to the adder path
    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_mul = 2'd2
    } alu_op_t;

    // ================================================
    // Exception flags
    // ================================================

    // Same order as the flags word of the ALU port, msb first
    typedef struct packed {
        // Result was rounded or truncated
        logic inexact;
        // NaN input or undefined operation
        logic invalid;
        // Result exceeded the largest finite value
        logic overflow;
        // Result was flushed to zero
        logic underflow;
    } fp_flags_t;

endpackage

// File: logic/fp_add_sub.sv
// ================================================
// FP adder/subtractor
// Combinational IEEE-754 add and subtract, round to nearest even
// ================================================
`timescale 1ns/1ps

module fp_add_sub #(
    parameter int exp_bits = fp_alu_pkg::default_exp_bits,
    parameter int man_bits = fp_alu_pkg::default_man_bits
) (
    input  logic [exp_bits+man_bits:0] a,
    input  logic [exp_bits+man_bits:0] b,
    input  logic                       sub,
    output logic [exp_bits+man_bits:0] result,
    output fp_alu_pkg::fp_flags_t      flags
);

    localparam int width = 1 + exp_bits + man_bits;
    // Carry, hidden bit, fraction, guard, round, sticky
    localparam int sig_w = man_bits + 5;
    localparam logic [exp_bits-1:0] exp_ones = '1;
    localparam logic [width-1:0] quiet_nan = {1'b0, exp_ones, 1'b1, {(man_bits - 1){1'b0}}};

    // ================================================
    // Operand fields
    // ================================================
    logic                sign_a;
    logic                sign_b_eff;
    logic [exp_bits-1:0] exp_a;
    logic [exp_bits-1:0] exp_b;
    logic [man_bits-1:0] frac_a;
    logic [man_bits-1:0] frac_b;
    logic [exp_bits-1:0] exp_a_eff;
    logic [exp_bits-1:0] exp_b_eff;
    logic                is_nan_a;
    logic                is_nan_b;
    logic                is_inf_a;
    logic                is_inf_b;
    logic                is_zero_a;
    logic                is_zero_b;

    // Ordered by magnitude
    logic                a_larger;
    logic                same_sign;
    logic                sign_big;
    logic [exp_bits-1:0] exp_big;
    logic [exp_bits-1:0] exp_diff;
    logic [sig_w-1:0]    sig_a;
    logic [sig_w-1:0]    sig_b;
    logic [sig_w-1:0]    sig_big;
    logic [sig_w-1:0]    sig_small;
    logic [sig_w-1:0]    align_mask;

    // Datapath working values
    logic [sig_w-1:0]      sig_aligned;
    logic [sig_w-1:0]      sum;
    logic [exp_bits+1:0]   exp_res;
    logic [exp_bits+1:0]   lz;
    logic [man_bits+1:0]   rounded;
    logic                  round_up;

    assign sign_a     = a[width-1];
    assign sign_b_eff = b[width-1] ^ sub;
    assign exp_a      = a[width-2:man_bits];
    assign exp_b      = b[width-2:man_bits];
    assign frac_a     = a[man_bits-1:0];
    assign frac_b     = b[man_bits-1:0];

    assign is_nan_a  = (exp_a == exp_ones) && (frac_a != '0);
    assign is_nan_b  = (exp_b == exp_ones) && (frac_b != '0);
    assign is_inf_a  = (exp_a == exp_ones) && (frac_a == '0);
    assign is_inf_b  = (exp_b == exp_ones) && (frac_b == '0);
    assign is_zero_a = (exp_a == '0) && (frac_a == '0);
    assign is_zero_b = (exp_b == '0) && (frac_b == '0);

    // Subnormals use exponent 1 and no hidden bit
    assign exp_a_eff = (exp_a == '0) ? exp_bits'(1) : exp_a;
    assign exp_b_eff = (exp_b == '0) ? exp_bits'(1) : exp_b;
    assign sig_a     = {1'b0, |exp_a, frac_a, 3'b000};
    assign sig_b     = {1'b0, |exp_b, frac_b, 3'b000};

    // Swap so that the subtraction below never goes negative
    assign a_larger  = {exp_a, frac_a} >= {exp_b, frac_b};
    assign same_sign = (sign_a == sign_b_eff);
    assign sign_big  = a_larger ? sign_a : sign_b_eff;
    assign exp_big   = a_larger ? exp_a_eff : exp_b_eff;
    assign exp_diff  = a_larger ? exp_a_eff - exp_b_eff : exp_b_eff - exp_a_eff;
    assign sig_big   = a_larger ? sig_a : sig_b;
    assign sig_small = a_larger ? sig_b : sig_a;

    // Bits of the small operand that fall off the end during alignment
    assign align_mask = ~({sig_w{1'b1}} << exp_diff);

    always_comb begin
        result      = '0;
        flags       = '0;
        sig_aligned = '0;
        sum         = '0;
        exp_res     = '0;
        lz          = '0;
        rounded     = '0;
        round_up    = 1'b0;

        // ================================================
        // Special operands, NaN then infinity then zero
        // ================================================
        if (is_nan_a || is_nan_b || (is_inf_a && is_inf_b && !same_sign)) begin
            result        = quiet_nan;
            flags.invalid = 1'b1;
        end else if (is_inf_a) begin
            result = a;
        end else if (is_inf_b) begin
            result = {sign_b_eff, exp_ones, {man_bits{1'b0}}};
        end else if (is_zero_a) begin
            result = {sign_b_eff, b[width-2:0]};
        end else if (is_zero_b) begin
            result = a;
        end else begin
            // Align, folding the lost bits into sticky
            sig_aligned    = sig_small >> exp_diff;
            sig_aligned[0] = sig_aligned[0] | (|(sig_small & align_mask));

            if (same_sign) begin
                sum = sig_big + sig_aligned;
            end else begin
                sum = sig_big - sig_aligned;
            end
            exp_res = {2'b00, exp_big};

            // Leading zeros below the carry position
            for (int i = 0; i <= man_bits + 3; i++) begin
                if (sum[i]) begin
                    lz = (exp_bits + 2)'(man_bits + 3 - i);
                end
            end

            if (sum == '0) begin
                // Exact cancellation is always +0
                result = '0;
            end else begin
                if (sum[sig_w-1]) begin
                    sum     = {1'b0, sum[sig_w-1:2], sum[1] | sum[0]};
                    exp_res = exp_res + 1'b1;
                end else if (exp_res > lz) begin
                    sum     = sum << lz;
                    exp_res = exp_res - lz;
                end else begin
                    flags.underflow = 1'b1;
                    flags.inexact   = 1'b1;
                end

                if (flags.underflow) begin
                    result = {sign_big, {(width - 1){1'b0}}};
                end else begin
                    // Nearest even: guard set and anything else or an odd lsb
                    round_up      = sum[2] & (sum[1] | sum[0] | sum[3]);
                    flags.inexact = |sum[2:0];
                    rounded       = {1'b0, sum[sig_w-2:3]} + (man_bits + 2)'(round_up);
                    if (rounded[man_bits+1]) begin
                        rounded = rounded >> 1;
                        exp_res = exp_res + 1'b1;
                    end

                    if (exp_res >= {2'b00, exp_ones}) begin
                        result         = {sign_big, exp_ones, {man_bits{1'b0}}};
                        flags.overflow = 1'b1;
                        flags.inexact  = 1'b1;
                    end else begin
                        result = {sign_big, exp_res[exp_bits-1:0], rounded[man_bits-1:0]};
                    end
                end
            end
        end
    end

endmodule

// File: logic/fp_mul.sv
// ================================================
// FP multiplier
// Combinational IEEE-754 multiply with a truncated fraction
// ================================================
`timescale 1ns/1ps

module fp_mul #(
    parameter int exp_bits = fp_alu_pkg::default_exp_bits,
    parameter int man_bits = fp_alu_pkg::default_man_bits
) (
    input  logic [exp_bits+man_bits:0] a,
    input  logic [exp_bits+man_bits:0] b,
    output logic [exp_bits+man_bits:0] result,
    output fp_alu_pkg::fp_flags_t      flags
);

    localparam int width   = 1 + exp_bits + man_bits;
    // Hidden bit plus fraction
    localparam int sig_w   = man_bits + 1;
    localparam int bias    = (1 << (exp_bits - 1)) - 1;
    localparam int exp_max = (1 << exp_bits) - 1;
    localparam logic [exp_bits-1:0] exp_ones = '1;
    localparam logic [width-1:0] quiet_nan = {1'b0, exp_ones, 1'b1, {(man_bits - 1){1'b0}}};

    logic                          sign_res;
    logic [exp_bits-1:0]           exp_a;
    logic [exp_bits-1:0]           exp_b;
    logic [man_bits-1:0]           frac_a;
    logic [man_bits-1:0]           frac_b;
    logic [exp_bits-1:0]           exp_a_eff;
    logic [exp_bits-1:0]           exp_b_eff;
    logic                          is_nan_a;
    logic                          is_nan_b;
    logic                          is_inf_a;
    logic                          is_inf_b;
    logic                          is_zero_a;
    logic                          is_zero_b;
    logic [sig_w-1:0]              sig_a;
    logic [sig_w-1:0]              sig_b;
    logic [2*sig_w-1:0]            product;
    // Signed so that small products can go below zero
    logic signed [exp_bits+2:0]    exp_sum;
    logic signed [exp_bits+2:0]    exp_norm;
    logic [man_bits-1:0]           frac_res;

    assign sign_res = a[width-1] ^ b[width-1];
    assign exp_a    = a[width-2:man_bits];
    assign exp_b    = b[width-2:man_bits];
    assign frac_a   = a[man_bits-1:0];
    assign frac_b   = b[man_bits-1:0];

    assign is_nan_a  = (exp_a == exp_ones) && (frac_a != '0);
    assign is_nan_b  = (exp_b == exp_ones) && (frac_b != '0);
    assign is_inf_a  = (exp_a == exp_ones) && (frac_a == '0);
    assign is_inf_b  = (exp_b == exp_ones) && (frac_b == '0);
    assign is_zero_a = (exp_a == '0) && (frac_a == '0);
    assign is_zero_b = (exp_b == '0) && (frac_b == '0);

    assign exp_a_eff = (exp_a == '0) ? exp_bits'(1) : exp_a;
    assign exp_b_eff = (exp_b == '0) ? exp_bits'(1) : exp_b;
    assign sig_a     = {|exp_a, frac_a};
    assign sig_b     = {|exp_b, frac_b};

    // ================================================
    // Significand product and biased exponent
    // ================================================
    assign product = sig_a * sig_b;
    assign exp_sum = $signed({3'b000, exp_a_eff}) + $signed({3'b000, exp_b_eff})
                     - (exp_bits + 3)'(bias);

    always_comb begin
        result   = '0;
        flags    = '0;
        exp_norm = exp_sum;
        frac_res = '0;

        if (is_nan_a || is_nan_b || (is_zero_a && is_inf_b) || (is_inf_a && is_zero_b)) begin
            result        = quiet_nan;
            flags.invalid = 1'b1;
        end else if (is_inf_a || is_inf_b) begin
            result = {sign_res, exp_ones, {man_bits{1'b0}}};
        end else if (is_zero_a || is_zero_b) begin
            result = {sign_res, {(width - 1){1'b0}}};
        end else begin
            // Product in [1,4), one bit of normalization at most
            if (product[2*sig_w-1]) begin
                exp_norm = exp_sum + 1;
                frac_res = product[2*man_bits:man_bits+1];
            end else begin
                frac_res = product[2*man_bits-1:man_bits];
            end

            if (exp_norm >= (exp_bits + 3)'(exp_max)) begin
                result         = {sign_res, exp_ones, {man_bits{1'b0}}};
                flags.overflow = 1'b1;
            end else if (exp_norm <= 0) begin
                result          = {sign_res, {(width - 1){1'b0}}};
                flags.underflow = 1'b1;
            end else begin
                result = {sign_res, exp_norm[exp_bits-1:0], frac_res};
            end
        end
    end

endmodule

// File: logic/fp_alu_pipe.sv
// ================================================
// FP ALU pipeline
// Request capture, unit select and registered result, two cycles
// ================================================
`timescale 1ns/1ps

module fp_alu_pipe #(
    parameter int exp_bits = fp_alu_pkg::default_exp_bits,
    parameter int man_bits = fp_alu_pkg::default_man_bits
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  fp_alu_pkg::alu_op_t        op,
    input  logic [exp_bits+man_bits:0] op_a,
    input  logic [exp_bits+man_bits:0] op_b,
    output logic [exp_bits+man_bits:0] result,
    output fp_alu_pkg::fp_flags_t      flags,
    output logic                       valid
);

    // Capture stage
    logic                       s1_valid;
    fp_alu_pkg::alu_op_t        s1_op;
    logic [exp_bits+man_bits:0] s1_a;
    logic [exp_bits+man_bits:0] s1_b;

    // Unit outputs
    logic [exp_bits+man_bits:0] add_result;
    logic [exp_bits+man_bits:0] mul_result;
    logic [exp_bits+man_bits:0] sel_result;
    fp_alu_pkg::fp_flags_t      add_flags;
    fp_alu_pkg::fp_flags_t      mul_flags;
    fp_alu_pkg::fp_flags_t      sel_flags;

    // Result stage
    logic                       s2_valid;
    logic [exp_bits+man_bits:0] s2_result;
    fp_alu_pkg::fp_flags_t      s2_flags;

    // ================================================
    // Stage 1
    // ================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            s1_op <= op;
            s1_a  <= op_a;
            s1_b  <= op_b;
        end
    end

    fp_add_sub #(
        .exp_bits (exp_bits),
        .man_bits (man_bits)
    ) u_add_sub (
        .a      (s1_a),
        .b      (s1_b),
        .sub    (s1_op == fp_alu_pkg::op_sub),
        .result (add_result),
        .flags  (add_flags)
    );

    fp_mul #(
        .exp_bits (exp_bits),
        .man_bits (man_bits)
    ) u_mul (
        .a      (s1_a),
        .b      (s1_b),
        .result (mul_result),
        .flags  (mul_flags)
    );

    assign sel_result = (s1_op == fp_alu_pkg::op_mul) ? mul_result : add_result;
    assign sel_flags  = (s1_op == fp_alu_pkg::op_mul) ? mul_flags : add_flags;

    // ================================================
    // Stage 2, selected unit result
    // ================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_result <= sel_result;
            s2_flags  <= sel_flags;
        end
    end

    // ================================================
    // Output stage, holds between requests
    // ================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid  <= 1'b0;
            result <= '0;
            flags  <= '0;
        end else begin
            valid <= s2_valid;
            if (s2_valid) begin
                result <= s2_result;
                flags  <= s2_flags;
            end
        end
    end

endmodule

// File: logic/fp_alu_top.sv
// ================================================
// FP ALU top level
// Fixes the number format and exposes the start/valid ports
// ================================================
`timescale 1ns/1ps

module fp_alu_top #(
    // Binary32 by default, 5 and 10 give half precision
    parameter int exp_bits = fp_alu_pkg::default_exp_bits,
    parameter int man_bits = fp_alu_pkg::default_man_bits
) (
    input  logic                       clk,
    input  logic                       rst,
    // One-cycle request strobe
    input  logic                       start,
    input  fp_alu_pkg::alu_op_t        op,
    input  logic [exp_bits+man_bits:0] op_a,
    input  logic [exp_bits+man_bits:0] op_b,
    // Valid pulses two cycles after start
    output logic [exp_bits+man_bits:0] result,
    output fp_alu_pkg::fp_flags_t      flags,
    output logic                       valid
);

    fp_alu_pipe #(
        .exp_bits (exp_bits),
        .man_bits (man_bits)
    ) u_pipe (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .op_a   (op_a),
        .op_b   (op_b),
        .result (result),
        .flags  (flags),
        .valid  (valid)
    );

endmodule

// File: tb/fp_alu_checks.svh
// ================================================
// FP ALU testbench checks
// Compare tasks for result word, flags and valid timing
// ================================================

// Result word against its expected value
task automatic check_result(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
        abort_run($sformatf("error at %0d ns: %s expected %h, actual %h",
                            $time, name, expected, actual));
    end
endtask

// Flags in the order inexact, invalid, overflow, underflow
task automatic check_flags(input string name, input fp_alu_pkg::fp_flags_t expected,
                           input fp_alu_pkg::fp_flags_t actual);
    if (actual !== expected) begin
        abort_run($sformatf("error at %0d ns: %s expected %b, actual %b",
                            $time, name, expected, actual));
    end
endtask

// One valid pulse per request, exactly on its due cycle
task automatic check_valid_timing(input logic seen, input bit pending, input int due,
                                  input int now);
    if (seen !== 1'b0 && seen !== 1'b1) begin
        abort_run($sformatf("valid is unknown at cycle %0d", now));
    end else if (seen && !pending) begin
        abort_run($sformatf("valid pulsed at cycle %0d with no request outstanding", now));
    end else if (seen && due != now) begin
        abort_run($sformatf("valid came at cycle %0d but was due at cycle %0d", now, due));
    end else if (!seen && pending && now >= due) begin
        abort_run($sformatf("valid missing at cycle %0d for an outstanding request", now));
    end
endtask

// File: tb/fp_alu_tb.sv
// ================================================
// FP ALU testbench
// Trace-driven requests checked against a two-cycle scoreboard
// ================================================
`timescale 1ns/1ps

module fp_alu_tb;

    localparam int width          = 1 + fp_alu_pkg::default_exp_bits
                                      + fp_alu_pkg::default_man_bits;
    localparam int max_lines      = 64;
    localparam int line_words     = 5;
    localparam int rand_seed      = 30;
    localparam int half_period    = 4;
    localparam int timeout_margin = 50;
    localparam int latency        = 2;
    localparam trace_path         = "tb/fp_alu_trace.txt";
    localparam logic [31:0] end_marker = 32'hff;

    typedef logic [width-1:0] word_t;

    // One scoreboard entry per request
    typedef struct packed {
        word_t                 result;
        fp_alu_pkg::fp_flags_t flags;
        logic [31:0]           due;
    } expect_t;

    logic                  clk;
    logic                  rst;
    logic                  start;
    fp_alu_pkg::alu_op_t   op;
    word_t                 op_a;
    word_t                 op_b;
    word_t                 result;
    fp_alu_pkg::fp_flags_t flags;
    logic                  valid;

    logic [31:0] trace_mem [0:max_lines*line_words-1];
    expect_t     expect_q [$];
    expect_t     head;
    expect_t     entry;
    int          n_lines;
    int          checked;
    int          cycle;
    int          timeout_cycles;
    int          gap;
    int          base;
    int          seed_value;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopped at the first failure");
    endtask

    `include "fp_alu_checks.svh"

    fp_alu_top dut0 (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .op_a   (op_a),
        .op_b   (op_b),
        .result (result),
        .flags  (flags),
        .valid  (valid)
    );

    initial clk = 1'b0;
    always #half_period clk = ~clk;

    // ================================================
    // Cycle count and timeout
    // ================================================
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            abort_run($sformatf("timeout, run not done after %0d cycles", cycle));
        end
    end

    // Valid and outputs are stable at the falling edge
    always @(negedge clk) begin
        if (expect_q.size() > 0) begin
            check_valid_timing(valid, 1'b1, expect_q[0].due, cycle);
        end else begin
            check_valid_timing(valid, 1'b0, 0, cycle);
        end
        if (valid === 1'b1) begin
            head = expect_q.pop_front();
            check_result("result", head.result, result);
            check_flags("flags", head.flags, flags);
            checked = checked + 1;
        end
    end

    // ================================================
    // Stimulus
    // ================================================
    initial begin
        rst            = 1'b1;
        start          = 1'b0;
        op             = fp_alu_pkg::op_add;
        op_a           = '0;
        op_b           = '0;
        checked        = 0;
        cycle          = 0;
        timeout_cycles = 4 * max_lines + timeout_margin;
        seed_value     = $urandom(rand_seed);

        $readmemh(trace_path, trace_mem);
        n_lines = 0;
        while (n_lines < max_lines && trace_mem[n_lines*line_words] !== end_marker) begin
            n_lines++;
        end
        if (n_lines == 0 || n_lines == max_lines) begin
            abort_run("trace file is empty or lacks its end marker");
        end
        timeout_cycles = 4 * n_lines + timeout_margin;

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        check_result("result", '0, result);
        check_flags("flags", '0, flags);

        // Idle cycles, valid must stay low
        repeat (2) @(posedge clk);

        for (int i = 0; i < n_lines; i++) begin
            base = i * line_words;
            gap  = $urandom_range(2, 0);
            repeat (gap) begin
                @(posedge clk);
                #1;
                start = 1'b0;
            end
            @(posedge clk);
            #1;
            start = 1'b1;
            op    = fp_alu_pkg::alu_op_t'(trace_mem[base][1:0]);
            op_a  = trace_mem[base+1][width-1:0];
            op_b  = trace_mem[base+2][width-1:0];
            entry.result = trace_mem[base+3][width-1:0];
            entry.flags  = fp_alu_pkg::fp_flags_t'(trace_mem[base+4][3:0]);
            // Sampled at the next edge, result due latency edges later
            entry.due    = cycle + 1 + latency;
            expect_q.push_back(entry);
        end
        @(posedge clk);
        #1;
        start = 1'b0;

        while (checked < n_lines) @(negedge clk);
        // A few spare cycles to catch stray valid pulses
        repeat (4) @(negedge clk);

        $display("** PASS **");
        $finish;
    end

endmodule

// File: fp_alu.f
+incdir+tb
logic/fp_alu_pkg.sv
logic/fp_add_sub.sv
logic/fp_mul.sv
logic/fp_alu_pipe.sv
logic/fp_alu_top.sv
tb/fp_alu_tb.sv

// File: tb/fp_alu_trace.txt
// Columns: op a b expected_result expected_flags, all hex; op 0 add, 1 sub, 2 mul
// Flags bits msb first: inexact invalid overflow underflow; op ff ends the trace
0 3f800000 40000000 40400000 0
1 40400000 3f800000 40000000 0
1 3fc00000 3fc00000 00000000 0
0 3f800000 33800000 3f800000 8
0 3f800001 33800000 3f800002 8
0 3f800000 33c00000 3f800001 8
0 3f800000 30800000 3f800000 8
0 3fc00000 3ec00000 3ff00000 0
0 3f800000 3f800001 40000000 8
1 3f800000 3f400000 3e800000 0
1 3f800000 33000000 3f800000 8
0 c0000000 3f800000 bf800000 0
0 7f800001 3f800000 7fc00000 4
1 7f800000 7f800000 7fc00000 4
0 ff800000 40000000 ff800000 0
1 3f800000 7f800000 ff800000 0
0 00000000 c0400000 c0400000 0
1 00000000 c0000000 40000000 0
1 40800000 00000000 40800000 0
0 7f7fffff 7f7fffff 7f800000 a
1 ff7fffff 7f7fffff ff800000 a
0 7f7fffff 73000000 7f800000 a
2 40400000 3fc00000 40900000 0
2 c0000000 3fc00000 c0400000 0
2 3fc00000 3f800001 3fc00001 0
2 3fffffff 3fffffff 407ffffe 0
2 00000000 7f800000 7fc00000 4
2 7f800000 c0000000 ff800000 0
2 80000000 40400000 80000000 0
2 7f000000 40000000 7f800000 2
2 ff000000 7f000000 ff800000 2
2 00800000 3f000000 00000000 1
2 80800000 3e800000 80000000 1
2 00800000 40000000 01000000 0
ff 00000000 00000000 00000000 0
